// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= door_lock_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
src/lock_pkg.sv
src/code_store.sv
src/button_debounce.sv
src/code_checker.sv
src/attempt_limiter.sv
src/door_fsm.sv
src/panel_output.sv
src/door_lock_top.sv
verification/door_lock_tb.sv

// ==== src/attempt_limiter.sv ====
module attempt_limiter #(
    parameter int MAX_ATTEMPTS      = 5,
    parameter int SHORT_WAIT_CYCLES = 1000,
    parameter int LONG_BLOCK_CYCLES = 30000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fail,
    input  logic                  clear,
    output logic                  released,
    output lock_pkg::fail_count_t fail_count
);
    import lock_pkg::*;

    localparam int WAIT_MAX = (LONG_BLOCK_CYCLES > SHORT_WAIT_CYCLES) ?
                              LONG_BLOCK_CYCLES : SHORT_WAIT_CYCLES;
    localparam int TW = $clog2(WAIT_MAX + 1);

    fail_count_t    count_next;
    logic           long_next;
    logic [TW-1:0]  wait_cnt;
    logic           waiting;
    logic           long_q;     // Current wait is the long block

    assign count_next = (fail_count == 3'd7) ? fail_count : fail_count + 1'b1;
    assign long_next  = (int'(count_next) > MAX_ATTEMPTS);
    assign released   = waiting && (wait_cnt == '0);  // Last cycle of the wait

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fail_count <= '0;
            wait_cnt   <= '0;
            waiting    <= 1'b0;
            long_q     <= 1'b0;
        end else begin
            if (fail) begin
                fail_count <= count_next;
                waiting    <= 1'b1;
                long_q     <= long_next;
                wait_cnt   <= long_next ? TW'(LONG_BLOCK_CYCLES - 1) :
                                          TW'(SHORT_WAIT_CYCLES - 1);
            end else if (released) begin
                waiting <= 1'b0;
                if (long_q) fail_count <= '0;  // Fresh start after a lockout
            end else if (waiting) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            if (clear) fail_count <= '0;
        end
    end

endmodule

// ==== src/button_debounce.sv ====
module button_debounce #(
    parameter int DEBOUNCE_CYCLES = 100
) (
    input  logic clk,
    input  logic rst,
    input  logic inside_button,
    output logic press
);

    localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CW-1:0] HOLD_MAX = CW'(DEBOUNCE_CYCLES);

    logic [CW-1:0] hold_cnt;

    // Count the high time, then judge it when the button is let go
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_cnt <= '0;
            press    <= 1'b0;
        end else if (inside_button) begin
            press <= 1'b0;
            if (hold_cnt != HOLD_MAX) begin
                hold_cnt <= hold_cnt + 1'b1;  // Saturates at the threshold
            end
        end else begin
            press    <= (hold_cnt == HOLD_MAX);  // Short touches and bounces drop out
            hold_cnt <= '0;
        end
    end

endmodule

// ==== src/code_checker.sv ====
module code_checker (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  lock_pkg::code_t entry_code,
    output lock_pkg::slot_t read_slot,
    input  lock_pkg::code_t read_code,
    output logic            done,
    output logic            match
);
    import lock_pkg::*;

    localparam slot_t LAST_SLOT = slot_t'(NUM_SLOTS - 1);

    code_t typed_q;   // Typed code under test
    slot_t slot_q;
    logic  busy;
    logic  equal;

    assign equal     = (read_code == typed_q);
    assign read_slot = slot_q;

    // Finish on the first hit, or on the last slot with no hit
    assign match = busy && equal;
    assign done  = busy && (equal || slot_q == LAST_SLOT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            slot_q <= '0;
        end else if (start) begin
            busy   <= 1'b1;
            slot_q <= '0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            slot_q <= slot_q + 1'b1;  // Next stored code
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            typed_q <= entry_code;
        end
    end

endmodule

// ==== src/code_store.sv ====
module code_store (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_valid,
    input  lock_pkg::slot_t load_slot,
    input  lock_pkg::code_t load_code,
    input  lock_pkg::slot_t read_slot,
    output lock_pkg::code_t read_code
);
    import lock_pkg::*;

    code_t slots [NUM_SLOTS];

    // Empty slots hold all F, which no typed code can start with
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i] <= EMPTY_CODE;
            end
        end else if (load_valid) begin
            slots[load_slot] <= load_code;
        end
    end

    assign read_code = slots[read_slot];  // Asynchronous read

endmodule

// ==== src/door_fsm.sv ====
module door_fsm #(
    parameter int RELOCK_CYCLES = 5000,
    parameter int BEEP_CYCLES   = 5000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  door_open,
    input  logic                  press,
    input  logic                  entry_valid,
    input  lock_pkg::digit_t      entry_first,
    input  logic                  done,
    input  logic                  match,
    input  logic                  released,
    output logic                  start,
    output logic                  fail,
    output logic                  clear,
    output lock_pkg::door_state_t state
);
    import lock_pkg::*;

    localparam int RW = $clog2(RELOCK_CYCLES + 1);
    localparam int BW = $clog2(BEEP_CYCLES + 1);
    localparam logic [RW-1:0] RELOCK_LAST = RW'(RELOCK_CYCLES - 1);
    localparam logic [BW-1:0] BEEP_LAST   = BW'(BEEP_CYCLES - 1);

    door_state_t   state_next;
    logic [RW-1:0] relock_cnt;
    logic [BW-1:0] open_cnt;
    logic          is_code;  // First digit looks like a real code

    always_comb begin
        case (entry_first)
            KEY_HASH, KEY_TIMEOUT, KEY_EMPTY: is_code = 1'b0;
            default:                          is_code = 1'b1;
        endcase
    end

    // Button wins over a typed code arriving in the same cycle
    assign start = (state == CLOSED) && entry_valid && is_code && !press;
    assign fail  = (state == CHECKING) && done && !match;
    assign clear = ((state == CLOSED) && press) ||
                   ((state == CHECKING) && done && match);

    always_comb begin
        state_next = state;
        case (state)
            INIT:         if (!door_open) state_next = CLOSED;
            CLOSED: begin
                if (press) begin
                    state_next = AJAR;
                end else if (entry_valid && entry_first == KEY_TIMEOUT) begin
                    state_next = BEEP_TIMEOUT;
                end else if (start) begin
                    state_next = CHECKING;
                end
            end
            CHECKING:     if (done) state_next = match ? AJAR : LOCKOUT;
            LOCKOUT:      if (released) state_next = CLOSED;
            AJAR: begin
                if (door_open) state_next = OPEN;
                else if (press || relock_cnt == RELOCK_LAST) state_next = CLOSED;
            end
            OPEN: begin
                if (!door_open) state_next = AJAR;
                else if (open_cnt == BEEP_LAST) state_next = BEEP_OPEN;
            end
            BEEP_OPEN:    if (!door_open) state_next = AJAR;
            BEEP_TIMEOUT: state_next = CLOSED;  // Single beep cycle
            default:      state_next = INIT;
        endcase
    end

    // Timers run only while the state holds, so every entry restarts them
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= INIT;
            relock_cnt <= '0;
            open_cnt   <= '0;
        end else begin
            state      <= state_next;
            relock_cnt <= (state == AJAR && state_next == AJAR) ? relock_cnt + 1'b1 : '0;
            open_cnt   <= (state == OPEN && state_next == OPEN) ? open_cnt + 1'b1 : '0;
        end
    end

endmodule

// ==== src/door_lock_top.sv ====
module door_lock_top #(
    parameter int DEBOUNCE_CYCLES   = 100,
    parameter int RELOCK_CYCLES     = 5000,
    parameter int BEEP_CYCLES       = 5000,
    parameter int MAX_ATTEMPTS      = 5,
    parameter int SHORT_WAIT_CYCLES = 1000,
    parameter int LONG_BLOCK_CYCLES = 30000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               door_open,
    input  logic               inside_button,
    input  logic               entry_valid,
    input  lock_pkg::code_t    entry_code,
    input  logic               load_valid,
    input  lock_pkg::slot_t    load_slot,
    input  lock_pkg::code_t    load_code,
    output lock_pkg::display_t display,
    output logic               keypad_en,
    output logic               lock,
    output logic               beep
);
    import lock_pkg::*;

    slot_t       read_slot;
    code_t       read_code;
    digit_t      entry_first;
    door_state_t state;
    fail_count_t fail_count;
    logic        press, start, done, match, fail, clear, released;

    assign entry_first = entry_code[0];  // First digit typed

    code_store u_store (.clk, .rst, .load_valid, .load_slot, .load_code,
                        .read_slot, .read_code);

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_debounce (
        .clk, .rst, .inside_button, .press);

    code_checker u_checker (.clk, .rst, .start, .entry_code, .read_slot,
                            .read_code, .done, .match);

    attempt_limiter #(
        .MAX_ATTEMPTS     (MAX_ATTEMPTS),
        .SHORT_WAIT_CYCLES(SHORT_WAIT_CYCLES),
        .LONG_BLOCK_CYCLES(LONG_BLOCK_CYCLES)
    ) u_limiter (.clk, .rst, .fail, .clear, .released, .fail_count);

    door_fsm #(.RELOCK_CYCLES(RELOCK_CYCLES), .BEEP_CYCLES(BEEP_CYCLES)) u_fsm (
        .clk, .rst, .door_open, .press, .entry_valid, .entry_first, .done,
        .match, .released, .start, .fail, .clear, .state);

    panel_output u_panel (.clk, .rst, .state, .fail_count, .display,
                          .keypad_en, .lock, .beep);

endmodule

// ==== src/lock_pkg.sv ====
package lock_pkg;

    typedef logic [3:0] digit_t;  // One keypad or display digit

    localparam int CODE_DIGITS = 20;
    typedef digit_t [CODE_DIGITS-1:0] code_t;  // Digit 0 is typed first

    localparam int NUM_SLOTS = 4;
    typedef logic [1:0] slot_t;

    localparam int DISPLAY_DIGITS = 6;
    typedef digit_t [DISPLAY_DIGITS-1:0] display_t;

    // Special keypad values
    localparam digit_t KEY_HASH    = 4'hB;
    localparam digit_t KEY_TIMEOUT = 4'hE;
    localparam digit_t KEY_EMPTY   = 4'hF;

    // Display glyphs
    localparam digit_t MARK_FAIL  = 4'hA;
    localparam digit_t MARK_BLANK = 4'hB;

    localparam code_t EMPTY_CODE = {CODE_DIGITS{KEY_EMPTY}};

    typedef enum logic [2:0] {
        INIT,
        CLOSED,        // Latched shut
        AJAR,          // Unlatched, door still against the frame
        OPEN,
        CHECKING,
        LOCKOUT,
        BEEP_TIMEOUT,
        BEEP_OPEN
    } door_state_t;

    typedef logic [2:0] fail_count_t;  // Saturates at 7

endpackage

// ==== src/panel_output.sv ====
module panel_output (
    input  logic                  clk,
    input  logic                  rst,
    input  lock_pkg::door_state_t state,
    input  lock_pkg::fail_count_t fail_count,
    output lock_pkg::display_t    display,
    output logic                  keypad_en,
    output logic                  lock,
    output logic                  beep
);
    import lock_pkg::*;

    display_t disp_next;

    // Fail marks fill from digit 0 and a count above 6 fills all six
    always_comb begin
        for (int i = 0; i < DISPLAY_DIGITS; i++) begin
            if (state == LOCKOUT && int'(fail_count) > i) disp_next[i] = MARK_FAIL;
            else                                          disp_next[i] = MARK_BLANK;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            display   <= {DISPLAY_DIGITS{MARK_BLANK}};
            keypad_en <= 1'b0;
            lock      <= 1'b0;
            beep      <= 1'b0;
        end else begin
            display   <= disp_next;
            lock      <= (state inside {CLOSED, CHECKING, LOCKOUT, BEEP_TIMEOUT});
            keypad_en <= (state inside {CLOSED, BEEP_TIMEOUT});
            beep      <= (state inside {BEEP_TIMEOUT, BEEP_OPEN});
        end
    end

endmodule

// ==== verification/door_lock_tb.sv ====
module door_lock_tb;
    import lock_pkg::*;

    localparam int DEBOUNCE_CYCLES   = 4;
    localparam int RELOCK_CYCLES     = 40;
    localparam int BEEP_CYCLES       = 30;
    localparam int MAX_ATTEMPTS      = 5;
    localparam int SHORT_WAIT_CYCLES = 10;
    localparam int LONG_BLOCK_CYCLES = 50;

    // Cycle budgets per test and the watchdog limit at twice their sum
    localparam int BUDGET_RESET  = 40;
    localparam int BUDGET_CODES  = 4 * (RELOCK_CYCLES + 20) + 40;
    localparam int BUDGET_FAILS  = 7 * (SHORT_WAIT_CYCLES + 20) + LONG_BLOCK_CYCLES;
    localparam int BUDGET_RELOCK = RELOCK_CYCLES + SHORT_WAIT_CYCLES + 40;
    localparam int BUDGET_OPEN   = BEEP_CYCLES + RELOCK_CYCLES + 30;
    localparam int BUDGET_BUTTON = 4 * (DEBOUNCE_CYCLES + 20);
    localparam int WATCHDOG_CYCLES = 2 * (BUDGET_RESET + BUDGET_CODES + BUDGET_FAILS +
                                          BUDGET_RELOCK + BUDGET_OPEN + BUDGET_BUTTON);

    localparam display_t BLANK = {DISPLAY_DIGITS{MARK_BLANK}};
    localparam int SEL_LOCK   = 0;
    localparam int SEL_KEYPAD = 1;
    localparam int SEL_BEEP   = 2;

    logic     clk = 1'b0;
    logic     rst, door_open, inside_button, entry_valid, load_valid;
    code_t    entry_code, load_code;
    slot_t    load_slot;
    display_t display;
    logic     keypad_en, lock, beep;

    logic [31:0] lfsr;
    code_t       stored [NUM_SLOTS];  // Model of the code store
    int          fails_m;             // Model failure count
    logic        exp_lock;            // Model lock level between tests
    int          errors, checks, tests, failed_tests, test_err0;
    string       test_name;

    door_lock_top #(
        .DEBOUNCE_CYCLES  (DEBOUNCE_CYCLES),
        .RELOCK_CYCLES    (RELOCK_CYCLES),
        .BEEP_CYCLES      (BEEP_CYCLES),
        .MAX_ATTEMPTS     (MAX_ATTEMPTS),
        .SHORT_WAIT_CYCLES(SHORT_WAIT_CYCLES),
        .LONG_BLOCK_CYCLES(LONG_BLOCK_CYCLES)
    ) u_dut (.clk, .rst, .door_open, .inside_button, .entry_valid, .entry_code,
             .load_valid, .load_slot, .load_code, .display, .keypad_en, .lock, .beep);

    always #50 clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};  // One step per bit
        end
    endtask

    task automatic draw_code(output code_t c);
        logic [31:0] v;
        for (int d = 1; d < CODE_DIGITS; d++) begin
            draw_bits(4, v);
            c[d] = v[3:0];
        end
        draw_bits(4, v);
        while (v[3:0] == 4'hB || v[3:0] == 4'hE || v[3:0] == 4'hF) draw_bits(4, v);
        c[0] = v[3:0];
    endtask

    function automatic bit in_store(input code_t c);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (stored[i] == c) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Marks fill up from digit 0
    function automatic display_t expected_marks(input int n);
        display_t d;
        for (int i = 0; i < DISPLAY_DIGITS; i++) d[i] = (i < n) ? MARK_FAIL : MARK_BLANK;
        return d;
    endfunction

    function automatic logic sig_now(input int sel);
        case (sel)
            SEL_LOCK:   return lock;
            SEL_KEYPAD: return keypad_en;
            default:    return beep;
        endcase
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic wait_signal(input int sel, input logic v, input int limit,
                               input string what, output int n);
        n = 0;
        while (sig_now(sel) !== v && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (sig_now(sel) !== v) begin
            errors++;
            $display("Timeout at %0t: %s did not become %0b within %0d cycles",
                     $time, what, v, limit);
        end
    endtask

    task automatic store_code(input int s, input code_t c);
        load_slot  = slot_t'(s);
        load_code  = c;
        load_valid = 1'b1;
        @(negedge clk);
        load_valid = 1'b0;
        stored[s]  = c;
    endtask

    task automatic type_code(input code_t c);
        entry_code  = c;
        entry_valid = 1'b1;
        @(negedge clk);
        entry_valid = 1'b0;
    endtask

    task automatic hold_button(input int cycles);
        inside_button = 1'b1;
        repeat (cycles) @(negedge clk);
        inside_button = 1'b0;
    endtask

    // Door stays shut and the keypad stays live while beep cycles are counted
    task automatic watch_closed(input int cycles, output int beeps);
        beeps = 0;
        repeat (cycles) begin
            @(negedge clk);
            compare(32'(lock), 32'd1, "lock while closed");
            compare(32'(keypad_en), 32'd1, "keypad_en while closed");
            if (beep) beeps++;
        end
    endtask

    // One wrong code, then follow the lockout until the keypad is back
    task automatic wrong_code_try();
        code_t c;
        int    n, n2;
        bit    long_wait, marks_seen;
        draw_code(c);
        while (in_store(c)) draw_code(c);
        type_code(c);
        if (fails_m < 7) fails_m++;
        long_wait = (fails_m > MAX_ATTEMPTS);
        wait_signal(SEL_KEYPAD, 1'b0, 6, "keypad_en after a wrong code", n);
        n2 = 0;
        marks_seen = 1'b0;
        while (keypad_en !== 1'b1 &&
               n2 < (long_wait ? LONG_BLOCK_CYCLES : SHORT_WAIT_CYCLES) + 8) begin
            compare(32'(lock), 32'd1, "lock during lockout");
            if (!marks_seen && display !== BLANK) begin
                compare(32'(display), 32'(expected_marks(fails_m)), "failure marks");
                marks_seen = 1'b1;
            end
            @(negedge clk);
            n2++;
        end
        if (keypad_en !== 1'b1) begin
            errors++;
            $display("Keypad stayed disabled after the wait at %0t", $time);
        end
        if (!marks_seen) begin
            errors++;
            $display("No failure marks were shown for a wrong code at %0t", $time);
        end
        if (long_wait) begin
            compare(32'(n2 >= LONG_BLOCK_CYCLES), 32'd1, "long lockout length");
            fails_m = 0;  // Count starts over after the long block
        end else begin
            compare(32'(n + n2 + 1 <= SHORT_WAIT_CYCLES + 6), 32'd1, "short wait length");
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        compare(32'(lock), 32'(exp_lock), "lock at end of test");
        tests++;
        if (errors != test_err0) failed_tests++;
        $display("test %0d %s: %s, %0d errors", tests, test_name,
                 (errors == test_err0) ? "ok" : "failed", errors - test_err0);
    endtask

    initial begin
        code_t       c;
        logic [31:0] v;
        int          n, beeps;

        rst = 1'b1;
        door_open = 1'b1;
        inside_button = 1'b0;
        entry_valid = 1'b0;
        entry_code = '0;
        load_valid = 1'b0;
        load_slot = '0;
        load_code = '0;
        lfsr = 32'hce25;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        fails_m = 0;
        exp_lock = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) stored[i] = EMPTY_CODE;

        begin_test("reset");
        repeat (8) @(negedge clk);
        compare(32'(lock), 32'd0, "lock in reset");
        compare(32'(keypad_en), 32'd0, "keypad_en in reset");
        compare(32'(beep), 32'd0, "beep in reset");
        compare(32'(display), 32'(BLANK), "display in reset");
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        compare(32'(lock), 32'd0, "lock before the door is shut");
        door_open = 1'b0;
        wait_signal(SEL_LOCK, 1'b1, 4, "lock after the door shut", n);
        compare(32'(keypad_en), 32'd1, "keypad_en after the door shut");
        exp_lock = 1'b1;
        end_test();

        begin_test("codes");
        for (int s = 0; s < NUM_SLOTS; s++) begin
            draw_code(c);
            store_code(s, c);
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            type_code(stored[s]);
            wait_signal(SEL_LOCK, 1'b0, 6, "lock after a stored code", n);
            fails_m = 0;
            wait_signal(SEL_LOCK, 1'b1, RELOCK_CYCLES + 4, "lock after relock", n);
        end
        draw_code(c);
        c[0] = KEY_HASH;
        type_code(c);
        watch_closed(8, beeps);
        compare(32'(beeps), 32'd0, "beep after a # key");
        c[0] = KEY_EMPTY;
        type_code(c);
        watch_closed(8, beeps);
        compare(32'(beeps), 32'd0, "beep after an empty first digit");
        c[0] = KEY_TIMEOUT;
        type_code(c);
        watch_closed(8, beeps);
        compare(32'(beeps), 32'd1, "beep cycles after a keypad timeout");
        end_test();

        begin_test("failures");
        for (int t = 0; t < MAX_ATTEMPTS + 2; t++) begin
            wrong_code_try();
        end
        end_test();

        begin_test("relock");
        draw_bits(2, v);
        type_code(stored[v[1:0]]);
        wait_signal(SEL_LOCK, 1'b0, 6, "lock after a stored code", n);
        fails_m = 0;
        wait_signal(SEL_LOCK, 1'b1, RELOCK_CYCLES + 4, "lock after relock", n);
        compare(32'(n >= RELOCK_CYCLES - 1), 32'd1, "relock not before the relock time");
        wrong_code_try();  // The unlock cleared the count, so one mark again
        end_test();

        begin_test("door open");
        draw_bits(2, v);
        type_code(stored[v[1:0]]);
        wait_signal(SEL_LOCK, 1'b0, 6, "lock after a stored code", n);
        door_open = 1'b1;
        wait_signal(SEL_BEEP, 1'b1, BEEP_CYCLES + 4, "beep with the door left open", n);
        compare(32'(n >= BEEP_CYCLES), 32'd1, "beep not before the beep time");
        compare(32'(lock), 32'd0, "lock while open");
        door_open = 1'b0;
        wait_signal(SEL_BEEP, 1'b0, 3, "beep after the door shut", n);
        wait_signal(SEL_LOCK, 1'b1, RELOCK_CYCLES + 4, "lock after relock", n);
        end_test();

        begin_test("button");
        hold_button(DEBOUNCE_CYCLES - 1);  // One cycle short of the threshold
        watch_closed(8, beeps);
        hold_button(DEBOUNCE_CYCLES + 2);
        wait_signal(SEL_LOCK, 1'b0, 6, "lock after a long press", n);
        hold_button(DEBOUNCE_CYCLES + 2);
        wait_signal(SEL_LOCK, 1'b1, 6, "lock after a second long press", n);
        end_test();

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
